// ==== source/pipe_pkg.sv ====
package pipe_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;   // 32 gprs
    localparam int ram_addr_w = 6;
    localparam int ram_words  = 1 << ram_addr_w;   // 64 words
    localparam int mul_cycles = 3;                 // cycles a mul sits in exe
    localparam int mul_cnt_w  = $clog2(mul_cycles);

    // decoded op, 4-bit field from decode
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_slt = 4'd5,   // signed compare
        alu_sll = 4'd6,   // shift by src2[4:0]
        alu_mul = 4'd7,   // low half of product
        alu_lw  = 4'd8,
        alu_sw  = 4'd9
    } alu_op_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_t               alu_op;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [15:0]           imm;     // signed offset, lw/sw only
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
    } ds_to_es_bus_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic                  ex;      // misaligned access
        logic                  gr_we;
        logic                  is_load;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       alu_result;
        logic [xlen-1:0]       mem_addr;
    } es_to_ms_bus_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic                  ex;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       final_result;
    } ms_to_ws_bus_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } ws_to_rf_bus_t;

endpackage

// ==== source/exe_stage.sv ====
module exe_stage import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // from decode
    input  logic                  ds_to_es_valid,
    input  ds_to_es_bus_t         ds_to_es_bus,
    output logic                  es_allowin,
    // to mem stage
    output logic                  es_to_ms_valid,
    output es_to_ms_bus_t         es_to_ms_bus,
    // data ram request
    output logic                  data_ram_en,
    output logic                  data_ram_we,
    output logic [ram_addr_w-1:0] data_ram_addr,
    output logic [xlen-1:0]       data_ram_wdata
);

    logic                 es_valid;
    logic                 es_ready_go;
    ds_to_es_bus_t        ds_to_es_bus_r;   // latched decode op
    logic [mul_cnt_w-1:0] mul_cnt;          // remaining stall cycles of a mul
    logic                 es_accept;

    logic                 is_load;
    logic                 is_store;
    logic [xlen-1:0]      mem_addr;
    logic                 es_ex;
    logic [xlen-1:0]      alu_result;
    logic [xlen-1:0]      imm_sext;

    assign es_ready_go    = (mul_cnt == '0);   // low while a mul counts down
    assign es_allowin     = !es_valid || es_ready_go;   // mem stage never busy
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_accept      = ds_to_es_valid && es_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_accept) ds_to_es_bus_r <= ds_to_es_bus;   // payload, no reset
    end

    // mul holds exe for mul_cycles-1 extra cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            mul_cnt <= '0;
        end else if (es_accept) begin
            mul_cnt <= (ds_to_es_bus.alu_op == alu_mul) ? mul_cnt_w'(mul_cycles - 1) : '0;
        end else if (mul_cnt != '0) begin
            mul_cnt <= mul_cnt - 1'b1;
        end
    end

    assign is_load  = (ds_to_es_bus_r.alu_op == alu_lw);
    assign is_store = (ds_to_es_bus_r.alu_op == alu_sw);
    assign imm_sext = {{(xlen-16){ds_to_es_bus_r.imm[15]}}, ds_to_es_bus_r.imm};
    assign mem_addr = ds_to_es_bus_r.src1 + imm_sext;
    assign es_ex    = (is_load || is_store) && (mem_addr[1:0] != 2'b00);   // word only

    always_comb begin
        case (ds_to_es_bus_r.alu_op)
            alu_add: alu_result = ds_to_es_bus_r.src1 + ds_to_es_bus_r.src2;
            alu_sub: alu_result = ds_to_es_bus_r.src1 - ds_to_es_bus_r.src2;
            alu_and: alu_result = ds_to_es_bus_r.src1 & ds_to_es_bus_r.src2;
            alu_or:  alu_result = ds_to_es_bus_r.src1 | ds_to_es_bus_r.src2;
            alu_xor: alu_result = ds_to_es_bus_r.src1 ^ ds_to_es_bus_r.src2;
            alu_slt: alu_result = {{(xlen-1){1'b0}},
                                   $signed(ds_to_es_bus_r.src1) < $signed(ds_to_es_bus_r.src2)};
            alu_sll: alu_result = ds_to_es_bus_r.src1 << ds_to_es_bus_r.src2[4:0];
            alu_mul: alu_result = ds_to_es_bus_r.src1 * ds_to_es_bus_r.src2;   // low 32 bits
            default: alu_result = mem_addr;   // lw/sw carry the address
        endcase
    end

    assign es_to_ms_bus = '{
        pc:         ds_to_es_bus_r.pc,
        ex:         es_ex,
        gr_we:      ds_to_es_bus_r.gr_we,
        is_load:    is_load,
        dest:       ds_to_es_bus_r.dest,
        alu_result: alu_result,
        mem_addr:   mem_addr
    };

    // ram sees the request on the edge the op moves to mem
    assign data_ram_en    = es_to_ms_valid && (is_load || is_store);
    assign data_ram_we    = es_to_ms_valid && is_store && !es_ex;   // no store on exception
    assign data_ram_addr  = mem_addr[ram_addr_w+1:2];
    assign data_ram_wdata = ds_to_es_bus_r.src2;

endmodule

// ==== source/mem_stage.sv ====
module mem_stage import pipe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    // from exe
    input  logic            es_to_ms_valid,
    input  es_to_ms_bus_t   es_to_ms_bus,
    // ram read data, one cycle after the request
    input  logic [xlen-1:0] data_ram_rdata,
    // to write-back
    output logic            ms_to_ws_valid,
    output ms_to_ws_bus_t   ms_to_ws_bus
);

    logic            ms_valid;
    es_to_ms_bus_t   es_to_ms_bus_r;
    logic            load_ok;         // load that actually read the ram
    logic [xlen-1:0] final_result;

    // never stalls, so no allowin here
    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid) es_to_ms_bus_r <= es_to_ms_bus;
    end

    assign load_ok = es_to_ms_bus_r.is_load && !es_to_ms_bus_r.ex;

    // misaligned load falls back to alu_result, its write is dropped in wb anyway
    assign final_result = load_ok ? data_ram_rdata : es_to_ms_bus_r.alu_result;

    assign ms_to_ws_valid = ms_valid;

    assign ms_to_ws_bus = '{
        pc:           es_to_ms_bus_r.pc,
        ex:           es_to_ms_bus_r.ex,
        gr_we:        es_to_ms_bus_r.gr_we,
        dest:         es_to_ms_bus_r.dest,
        final_result: final_result
    };

endmodule

// ==== source/data_ram.sv ====
module data_ram import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  en,
    input  logic                  we,
    input  logic [ram_addr_w-1:0] addr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata
);

    logic [xlen-1:0] mem [0:ram_words-1];   // contents not reset

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        // read-before-write, a write returns the old word
        if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== source/wb_stage.sv ====
module wb_stage import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // from mem
    input  logic                  ms_to_ws_valid,
    input  ms_to_ws_bus_t         ms_to_ws_bus,
    // register file write
    output ws_to_rf_bus_t         ws_to_rf_bus,
    // trace
    output logic                  debug_wb_valid,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata,
    // forwarding back to decode
    output logic [reg_addr_w-1:0] wb_dest,
    output logic [xlen-1:0]       wb_result
);

    logic          ws_valid;
    ms_to_ws_bus_t ms_to_ws_bus_r;
    logic          rf_we;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms_to_ws_valid;   // always accepts
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid) ms_to_ws_bus_r <= ms_to_ws_bus;
    end

    assign rf_we = ws_valid && ms_to_ws_bus_r.gr_we && !ms_to_ws_bus_r.ex;   // excepted op retires silently

    assign ws_to_rf_bus = '{
        we:    rf_we,
        waddr: ms_to_ws_bus_r.dest,
        wdata: ms_to_ws_bus_r.final_result
    };

    assign debug_wb_valid    = ws_valid;
    assign debug_wb_pc       = ms_to_ws_bus_r.pc;
    assign debug_wb_rf_wen   = {4{rf_we}};   // one bit per byte lane
    assign debug_wb_rf_wnum  = ms_to_ws_bus_r.dest;
    assign debug_wb_rf_wdata = ms_to_ws_bus_r.final_result;

    // dest masked so an empty stage never matches in decode
    assign wb_dest   = ms_to_ws_bus_r.dest & {reg_addr_w{ws_valid}};
    assign wb_result = ms_to_ws_bus_r.final_result;

endmodule

// ==== source/regfile.sv ====
module regfile import pipe_pkg::*; (
    input  logic                  clk,
    // read ports, combinational
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    // write port from wb
    input  ws_to_rf_bus_t         ws_to_rf_bus
);

    logic [xlen-1:0] rf [0:reg_count-1];   // no reset on contents

    always_ff @(posedge clk) begin
        if (ws_to_rf_bus.we && (ws_to_rf_bus.waddr != '0)) begin   // r0 stays untouched
            rf[ws_to_rf_bus.waddr] <= ws_to_rf_bus.wdata;
        end
    end

    // r0 forced to zero on read, its storage is never written
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// ==== source/pipe_backend.sv ====
module pipe_backend import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    // decode side
    input  logic                  ds_to_es_valid,
    input  ds_to_es_bus_t         ds_to_es_bus,
    output logic                  es_allowin,
    // register file reads
    input  logic [reg_addr_w-1:0] rf_raddr1,
    input  logic [reg_addr_w-1:0] rf_raddr2,
    output logic [xlen-1:0]       rf_rdata1,
    output logic [xlen-1:0]       rf_rdata2,
    // trace
    output logic                  debug_wb_valid,
    output logic [xlen-1:0]       debug_wb_pc,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [xlen-1:0]       debug_wb_rf_wdata,
    // forwarding
    output logic [reg_addr_w-1:0] wb_dest,
    output logic [xlen-1:0]       wb_result
);

    // exe -> mem
    logic                  es_to_ms_valid;
    es_to_ms_bus_t         es_to_ms_bus;
    // exe <-> ram
    logic                  data_ram_en;
    logic                  data_ram_we;
    logic [ram_addr_w-1:0] data_ram_addr;
    logic [xlen-1:0]       data_ram_wdata;
    logic [xlen-1:0]       data_ram_rdata;   // lands while op is in mem
    // mem -> wb
    logic                  ms_to_ws_valid;
    ms_to_ws_bus_t         ms_to_ws_bus;
    // wb -> rf
    ws_to_rf_bus_t         ws_to_rf_bus;

    exe_stage u_exe_stage (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .data_ram_en    (data_ram_en),
        .data_ram_we    (data_ram_we),
        .data_ram_addr  (data_ram_addr),
        .data_ram_wdata (data_ram_wdata)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .en    (data_ram_en),
        .we    (data_ram_we),
        .addr  (data_ram_addr),
        .wdata (data_ram_wdata),
        .rdata (data_ram_rdata)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .data_ram_rdata (data_ram_rdata),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .reset             (reset),
        .ms_to_ws_valid    (ms_to_ws_valid),
        .ms_to_ws_bus      (ms_to_ws_bus),
        .ws_to_rf_bus      (ws_to_rf_bus),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .wb_dest           (wb_dest),
        .wb_result         (wb_result)
    );

    regfile u_regfile (
        .clk          (clk),
        .raddr1       (rf_raddr1),
        .raddr2       (rf_raddr2),
        .rdata1       (rf_rdata1),
        .rdata2       (rf_rdata2),
        .ws_to_rf_bus (ws_to_rf_bus)
    );

endmodule

// ==== test/backend_model.svh ====
// one expected retire, in trace order
typedef struct packed {
    logic [xlen-1:0]       pc;
    logic                  we;
    logic [reg_addr_w-1:0] wnum;
    logic [xlen-1:0]       wdata;
} retire_t;

logic [xlen-1:0] model_regs [0:reg_count-1];
logic [xlen-1:0] model_mem  [0:ram_words-1];
retire_t         expect_q [$];   // filled at acceptance, drained at retire

// init pattern for ram word w, every address bit changes it
function automatic logic [xlen-1:0] fill_word(input int w);
    return xlen'(32'h9e37_79b9 * (w + 1));
endfunction

// applies one accepted op to the model state
task automatic model_apply(input ds_to_es_bus_t op);
    logic [xlen-1:0] addr;
    logic [xlen-1:0] result;
    logic            ex;
    retire_t         rec;
    addr   = op.src1 + {{(xlen-16){op.imm[15]}}, op.imm};   // sign-extended offset
    ex     = (op.alu_op == alu_lw || op.alu_op == alu_sw) && (addr[1:0] != 2'b00);
    result = '0;
    case (op.alu_op)
        alu_add: result = op.src1 + op.src2;
        alu_sub: result = op.src1 - op.src2;
        alu_and: result = op.src1 & op.src2;
        alu_or:  result = op.src1 | op.src2;
        alu_xor: result = op.src1 ^ op.src2;
        alu_slt: result = ($signed(op.src1) < $signed(op.src2)) ? 32'd1 : 32'd0;
        alu_sll: result = op.src1 << op.src2[4:0];
        alu_mul: result = op.src1 * op.src2;   // keep low word
        alu_lw:  if (!ex) result = model_mem[addr[ram_addr_w+1:2]];
        alu_sw:  if (!ex) model_mem[addr[ram_addr_w+1:2]] = op.src2;   // dropped when misaligned
        default: result = '0;
    endcase
    rec.pc    = op.pc;
    rec.we    = op.gr_we && !ex;
    rec.wnum  = op.dest;
    rec.wdata = result;
    if (rec.we && op.dest != '0) model_regs[op.dest] = result;   // r0 stays zero
    expect_q.push_back(rec);
endtask

// ==== test/pipe_backend_tb.sv ====
module pipe_backend_tb import pipe_pkg::*; ();

    localparam int num_random  = 600;
    localparam int num_init    = reg_count - 1 + ram_words;   // reg writes plus ram fill
    localparam int cycle_limit = (num_random + num_init + 8) * (mul_cycles + 1) + 200 + reg_count;
    localparam int drain_limit = mul_cycles + 4;   // last op accepted to last retire

    logic                  clk;
    logic                  reset;
    logic                  ds_to_es_valid;
    ds_to_es_bus_t         ds_to_es_bus;
    logic                  es_allowin;
    logic [reg_addr_w-1:0] rf_raddr1;
    logic [reg_addr_w-1:0] rf_raddr2;
    logic [xlen-1:0]       rf_rdata1;
    logic [xlen-1:0]       rf_rdata2;
    logic                  debug_wb_valid;
    logic [xlen-1:0]       debug_wb_pc;
    logic [3:0]            debug_wb_rf_wen;
    logic [reg_addr_w-1:0] debug_wb_rf_wnum;
    logic [xlen-1:0]       debug_wb_rf_wdata;
    logic [reg_addr_w-1:0] wb_dest;
    logic [xlen-1:0]       wb_result;

    integer          seed = 32'h37e01495;
    int              cycles = 0;
    logic [xlen-1:0] next_pc = 32'hbfc0_0000;
    logic            mul_pending = 1'b0;   // set by driver and cleared by checker

    `include "backend_model.svh"

    pipe_backend UUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the pipeline did not drain", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // drives one op and holds it until es_allowin lets it in
    task automatic issue_op(input ds_to_es_bus_t op);
        op.pc          = next_pc;
        next_pc        = next_pc + 4;
        ds_to_es_bus   = op;
        ds_to_es_valid = 1'b1;
        @(negedge clk);
        while (!es_allowin) @(negedge clk);   // held while a mul counts
        @(posedge clk);
        model_apply(op);
        if (op.alu_op == alu_mul) mul_pending = 1'b1;
        #1;
        ds_to_es_valid = 1'b0;
    endtask

    function automatic ds_to_es_bus_t make_op(input alu_op_t kind, input logic [xlen-1:0] src1,
                                              input logic [xlen-1:0] src2, input logic [15:0] imm,
                                              input logic [reg_addr_w-1:0] dest);
        ds_to_es_bus_t op;
        op.pc     = '0;   // filled at issue
        op.alu_op = kind;
        op.src1   = src1;
        op.src2   = src2;
        op.imm    = imm;
        op.dest   = dest;
        op.gr_we  = (kind != alu_sw);
        return op;
    endfunction

    function automatic ds_to_es_bus_t random_op();
        ds_to_es_bus_t op;
        op = make_op(alu_op_t'(4'(rand_below(10))), $random(seed), $random(seed),
                     16'($random(seed)), 5'(rand_below(reg_count)));
        if (op.alu_op == alu_lw || op.alu_op == alu_sw) begin
            op.src1 = 32'(64 + 4 * rand_below(32));   // keeps the address inside the ram
            op.imm  = 16'(4 * rand_below(32) - 64);
            if (rand_below(10) == 0) op.src1 = op.src1 + 32'(1 + rand_below(3));   // misaligned
        end
        return op;
    endfunction

    // trace check sampled mid-cycle
    always @(negedge clk) begin
        retire_t exp;
        if (!reset && debug_wb_valid) begin
            if (expect_q.size() == 0) begin
                $display("operation at pc %h retired with nothing outstanding", debug_wb_pc);
                $display("TESTBENCH FAILED");
                $fatal(1);
            end else begin
                exp = expect_q.pop_front();
                check_value("debug_wb_pc", exp.pc, debug_wb_pc);
                check_value("debug_wb_rf_wen", 32'({4{exp.we}}), 32'(debug_wb_rf_wen));
                check_value("wb_dest", 32'(exp.wnum), 32'(wb_dest));
                if (exp.we) begin   // number and data only matter on a write
                    check_value("debug_wb_rf_wnum", 32'(exp.wnum), 32'(debug_wb_rf_wnum));
                    check_value("debug_wb_rf_wdata", exp.wdata, debug_wb_rf_wdata);
                    check_value("wb_result", exp.wdata, wb_result);
                end
            end
        end else if (!reset) begin
            check_value("wb_dest", 32'd0, 32'(wb_dest));   // empty stage forwards nothing
        end
        if (mul_pending) begin
            check_value("es_allowin", 32'd0, 32'(es_allowin));   // mul must stall the front
            mul_pending = 1'b0;
        end
    end

    initial begin
        int i;
        int drain;
        clk            = 1'b0;
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        rf_raddr1      = '0;
        rf_raddr2      = '0;
        model_regs[0]  = '0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_value("debug_wb_valid", 32'd0, 32'(debug_wb_valid));
        check_value("debug_wb_rf_wen", 32'd0, 32'(debug_wb_rf_wen));
        check_value("wb_dest", 32'd0, 32'(wb_dest));
        check_value("es_allowin", 32'd1, 32'(es_allowin));
        @(posedge clk);
        #1;
        // known contents for every register and ram word
        for (i = 1; i < reg_count; i++) issue_op(make_op(alu_add, $random(seed), '0, '0, 5'(i)));
        for (i = 0; i < ram_words; i++) issue_op(make_op(alu_sw, 32'(4 * i), fill_word(i), '0, '0));
        issue_op(make_op(alu_add, 32'h1234_5678, 32'h1, '0, '0));   // r0 write ignored
        issue_op(make_op(alu_mul, 32'h0001_0003, 32'h0002_0005, '0, 5'd3));
        issue_op(make_op(alu_mul, 32'hffff_fff9, 32'h0000_0011, '0, 5'd4));   // back to back
        issue_op(make_op(alu_sub, 32'd5, 32'd9, '0, 5'd5));
        issue_op(make_op(alu_sw, 32'd40, 32'hdead_beef, 16'd2, '0));   // misaligned so no store
        issue_op(make_op(alu_lw, 32'd40, '0, '0, 5'd7));
        issue_op(make_op(alu_lw, 32'd44, '0, 16'd1, 5'd8));   // misaligned load
        for (i = 0; i < num_random; i++) begin
            while (rand_below(4) == 0) begin   // decode bubble
                @(posedge clk);
                #1;
            end
            issue_op(random_op());
        end
        drain = 0;
        while (expect_q.size() != 0 && drain < drain_limit) begin
            @(posedge clk);
            drain++;
        end
        if (expect_q.size() != 0) begin
            $display("%0d operations never retired", expect_q.size());
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        repeat (2) @(posedge clk);   // last write lands in the regfile
        #1;
        for (i = 0; i < reg_count; i++) begin
            rf_raddr1 = 5'(i);
            rf_raddr2 = 5'(reg_count - 1 - i);
            @(negedge clk);
            check_value("rf_rdata1", model_regs[i], rf_rdata1);
            check_value("rf_rdata2", model_regs[reg_count-1-i], rf_rdata2);
            @(posedge clk);
            #1;
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+test
source/pipe_pkg.sv
source/exe_stage.sv
source/mem_stage.sv
source/data_ram.sv
source/wb_stage.sv
source/regfile.sv
source/pipe_backend.sv
test/pipe_backend_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and decide on the pass line in the output
verilator --binary --timing -f project.f --top-module pipe_backend_tb -o pipe_backend_sim \
    && ./obj_dir/pipe_backend_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    || { echo "simulation did not pass"; exit 1; }
